// ==== dmem_macros.svh ====
/*
 * Build-time defaults for the data-memory subsystem
 * Bus width, bridge queue depth, SRAM size and SRAM wait states
 */
`ifndef DMEM_MACROS_SVH
`define DMEM_MACROS_SVH

// ---------------------------------------------------------------------------
// AHB-Lite bus
// ---------------------------------------------------------------------------

// Address and data width in bits
`define DMEM_AHB_WIDTH 32

// ---------------------------------------------------------------------------
// Bridge and SRAM defaults
// ---------------------------------------------------------------------------

// Request entries held in the bridge
`define DMEM_REQ_QUEUE_DEPTH 2

// SRAM size in 32-bit words, 1 KiB
`define DMEM_SRAM_WORDS 256

// Wait states inserted in each data phase
`define DMEM_SRAM_WAIT 1

`endif

// ==== dmem_pkg.sv ====
/*
 * Shared types for the data-memory path
 * Core-side command, width and response enums, AHB-Lite encodings,
 * transfer structs and the byte/word view of a bus word
 */
`include "dmem_macros.svh"

package dmem_pkg;

    // ------------------------------------------------------------------------
    // Core-side request and response
    // ------------------------------------------------------------------------
    typedef enum logic {
        mem_cmd_rd = 1'b0,
        mem_cmd_wr = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        mem_width_byte  = 2'b00,
        mem_width_hword = 2'b01,
        mem_width_word  = 2'b10,
        mem_width_err   = 2'b11
    } mem_width_e;

    typedef enum logic [1:0] {
        mem_resp_notrdy = 2'b00,
        mem_resp_rdy_ok = 2'b01,
        mem_resp_rdy_er = 2'b10
    } mem_resp_e;

    // ------------------------------------------------------------------------
    // AHB-Lite encodings
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        hsize_8b  = 3'b000,
        hsize_16b = 3'b001,
        hsize_32b = 3'b010
    } hsize_e;

    // Single transfers only, no SEQ or BUSY
    typedef enum logic [1:0] {
        htrans_idle   = 2'b00,
        htrans_nonseq = 2'b10
    } htrans_e;

    typedef enum logic {
        hresp_okay  = 1'b0,
        hresp_error = 1'b1
    } hresp_e;

    // ------------------------------------------------------------------------
    // Transfer structs
    // ------------------------------------------------------------------------
    typedef struct packed {
        mem_cmd_e                   cmd;
        mem_width_e                 width;
        logic [`DMEM_AHB_WIDTH-1:0] addr;
        logic [`DMEM_AHB_WIDTH-1:0] wdata;
    } dmem_req_s;

    // Master to slave
    typedef struct packed {
        htrans_e                    htrans;
        hsize_e                     hsize;
        logic                       hwrite;
        logic [`DMEM_AHB_WIDTH-1:0] haddr;
        logic [`DMEM_AHB_WIDTH-1:0] hwdata;
    } ahb_mst_s;

    // Slave to master
    typedef struct packed {
        logic                       hready;
        hresp_e                     hresp;
        logic [`DMEM_AHB_WIDTH-1:0] hrdata;
    } ahb_slv_s;

    // One bus word, whole or per byte lane
    typedef union packed {
        logic [`DMEM_AHB_WIDTH-1:0]        word;
        logic [`DMEM_AHB_WIDTH/8-1:0][7:0] bytes;
    } ahb_word_u;

endpackage

// ==== dmem_ahb_bridge.sv ====
/*
 * Core-to-AHB-Lite bridge for data loads and stores
 * Request queue, address/data phase FSM, write lane steering and
 * a registered response with read data aligned down to bit 0
 */
`timescale 1ns/1ps
`include "dmem_macros.svh"

module dmem_ahb_bridge
    import dmem_pkg::*;
#(
    parameter int queue_depth = `DMEM_REQ_QUEUE_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // Core side
    input  logic                       dmem_req,
    input  dmem_req_s                  dmem_cmd_in,
    output logic                       dmem_req_ack,
    output logic [`DMEM_AHB_WIDTH-1:0] dmem_rdata,
    output mem_resp_e                  dmem_resp,

    // AHB-Lite master side
    output ahb_mst_s                   ahb_out,
    input  ahb_slv_s                   ahb_in
);

    localparam int aw    = `DMEM_AHB_WIDTH;
    localparam int cnt_w = $clog2(queue_depth + 1);

    typedef enum logic {
        st_addr = 1'b0,
        st_data = 1'b1
    } phase_e;

    // Queued transfer, already in bus form
    typedef struct packed {
        logic          hwrite;
        hsize_e        hsize;
        logic [aw-1:0] haddr;
        logic [aw-1:0] hwdata;
    } queue_entry_s;

    // What the data phase and the response still need
    typedef struct packed {
        hsize_e        hsize;
        logic [1:0]    addr_lo;
        logic [aw-1:0] hwdata;
    } dphase_s;

    // ------------------------------------------------------------------------
    // Conversions between core and bus form
    // ------------------------------------------------------------------------
    function automatic hsize_e width_to_hsize(input mem_width_e width);
        hsize_e size;
        case (width)
            mem_width_byte:  size = hsize_8b;
            mem_width_hword: size = hsize_16b;
            default:         size = hsize_32b;
        endcase
        return size;
    endfunction

    // Move the low byte or halfword onto the lanes it addresses
    function automatic logic [aw-1:0] steer_wdata(
        input mem_width_e    width,
        input logic [1:0]    addr_lo,
        input logic [aw-1:0] wdata
    );
        logic [aw-1:0] lanes;
        case (width)
            mem_width_byte:  lanes = aw'(wdata[7:0]) << {addr_lo, 3'b000};
            mem_width_hword: lanes = aw'(wdata[15:0]) << {addr_lo[1], 4'b0000};
            default:         lanes = wdata;
        endcase
        return lanes;
    endfunction

    // Bring the addressed lanes down to bit 0, zeros above
    function automatic logic [aw-1:0] align_rdata(
        input hsize_e        size,
        input logic [1:0]    addr_lo,
        input logic [aw-1:0] rdata
    );
        logic [aw-1:0] shifted;
        logic [aw-1:0] aligned;
        case (size)
            hsize_8b: begin
                shifted = rdata >> {addr_lo, 3'b000};
                aligned = aw'(shifted[7:0]);
            end
            hsize_16b: begin
                shifted = rdata >> {addr_lo[1], 4'b0000};
                aligned = aw'(shifted[15:0]);
            end
            default: begin
                shifted = rdata;
                aligned = shifted;
            end
        endcase
        return aligned;
    endfunction

    queue_entry_s [queue_depth-1:0] queue_q;
    queue_entry_s [queue_depth-1:0] queue_d;
    queue_entry_s                   new_entry;
    logic [cnt_w-1:0]               count_q;
    logic [cnt_w-1:0]               count_d;
    logic                           queue_wr;
    logic                           queue_rd;
    logic                           queue_empty;
    logic                           queue_full;
    phase_e                         phase_q;
    logic                           issue;
    logic                           data_end;
    dphase_s                        dphase_q;

    // ------------------------------------------------------------------------
    // Request queue
    // ------------------------------------------------------------------------
    assign queue_full   = (count_q == cnt_w'(queue_depth));
    assign queue_empty  = (count_q == '0);
    assign dmem_req_ack = ~queue_full;
    assign queue_wr     = dmem_req & ~queue_full;

    always_comb begin
        new_entry.hwrite = (dmem_cmd_in.cmd == mem_cmd_wr);
        new_entry.hsize  = width_to_hsize(dmem_cmd_in.width);
        new_entry.haddr  = dmem_cmd_in.addr;
        new_entry.hwdata = steer_wdata(dmem_cmd_in.width, dmem_cmd_in.addr[1:0],
                                       dmem_cmd_in.wdata);
    end

    // Head is entry 0; a read shifts the rest down before the write lands
    always_comb begin
        queue_d = queue_q;
        count_d = count_q;
        if (queue_rd) begin
            for (int i = 0; i < queue_depth - 1; i++) begin
                queue_d[i] = queue_q[i + 1];
            end
            count_d = count_q - 1'b1;
        end
        if (queue_wr) begin
            queue_d[count_d] = new_entry;
            count_d          = count_d + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    always_ff @(posedge clk) begin
        queue_q <= queue_d;
    end

    // ------------------------------------------------------------------------
    // Phase FSM
    // ------------------------------------------------------------------------
    // In the data phase the next address goes out only on an OKAY completion,
    // so the second ERROR cycle always sees IDLE
    always_comb begin
        case (phase_q)
            st_addr: issue = ~queue_empty;
            st_data: issue = ahb_in.hready & (ahb_in.hresp == hresp_okay) & ~queue_empty;
            default: issue = 1'b0;
        endcase
    end

    assign queue_rd = issue & ahb_in.hready;
    assign data_end = (phase_q == st_data) & ahb_in.hready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_q <= st_addr;
        end else if (ahb_in.hready) begin
            phase_q <= queue_rd ? st_data : st_addr;
        end
    end

    // Address phase taken, head moves into the data phase
    always_ff @(posedge clk) begin
        if (queue_rd) begin
            dphase_q.hsize   <= queue_q[0].hsize;
            dphase_q.addr_lo <= queue_q[0].haddr[1:0];
            dphase_q.hwdata  <= queue_q[0].hwdata;
        end
    end

    // ------------------------------------------------------------------------
    // Response to the core
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmem_resp <= mem_resp_notrdy;
        end else if (data_end) begin
            dmem_resp <= (ahb_in.hresp == hresp_okay) ? mem_resp_rdy_ok : mem_resp_rdy_er;
        end else begin
            dmem_resp <= mem_resp_notrdy;
        end
    end

    always_ff @(posedge clk) begin
        if (data_end) begin
            dmem_rdata <= align_rdata(dphase_q.hsize, dphase_q.addr_lo, ahb_in.hrdata);
        end
    end

    // ------------------------------------------------------------------------
    // AHB-Lite master outputs
    // ------------------------------------------------------------------------
    always_comb begin
        ahb_out.htrans = issue ? htrans_nonseq : htrans_idle;
        ahb_out.hsize  = queue_q[0].hsize;
        ahb_out.hwrite = queue_q[0].hwrite;
        ahb_out.haddr  = queue_q[0].haddr;
        // Write data trails its address by one phase
        ahb_out.hwdata = dphase_q.hwdata;
    end

endmodule

// ==== ahb_sram_slave.sv ====
/*
 * AHB-Lite SRAM slave with byte-lane writes
 * Fixed wait states per data phase, two-cycle ERROR beyond the array
 */
`timescale 1ns/1ps
`include "dmem_macros.svh"

module ahb_sram_slave
    import dmem_pkg::*;
#(
    parameter int mem_words   = `DMEM_SRAM_WORDS,
    parameter int wait_states = `DMEM_SRAM_WAIT
) (
    input  logic     clk,
    input  logic     rst_n,
    input  ahb_mst_s ahb_in,
    output ahb_slv_s ahb_out
);

    localparam int aw     = `DMEM_AHB_WIDTH;
    localparam int lanes  = aw / 8;
    localparam int idx_w  = $clog2(mem_words);
    localparam int wcnt_w = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

    // First byte address past the array
    localparam logic [aw-1:0] mem_bytes = aw'(mem_words * lanes);

    ahb_word_u          mem [mem_words];
    ahb_word_u          wdata_u;
    logic               accept;
    logic               in_range;
    logic [lanes-1:0]   be_d;
    logic               dp_valid;
    logic               dp_last;
    logic               dp_write;
    logic [idx_w-1:0]   dp_idx;
    logic [lanes-1:0]   dp_be;
    logic [wcnt_w-1:0]  wcnt;
    logic               err_first;
    logic               err_second;

    // ------------------------------------------------------------------------
    // Address phase decode
    // ------------------------------------------------------------------------
    assign accept   = (ahb_in.htrans == htrans_nonseq) & ahb_out.hready;
    assign in_range = (ahb_in.haddr < mem_bytes);

    always_comb begin
        case (ahb_in.hsize)
            hsize_8b:  be_d = lanes'(1) << ahb_in.haddr[1:0];
            hsize_16b: be_d = lanes'(3) << {ahb_in.haddr[1], 1'b0};
            default:   be_d = '1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dp_write <= ahb_in.hwrite;
            dp_idx   <= ahb_in.haddr[idx_w+1:2];
            dp_be    <= be_d;
        end
    end

    // ------------------------------------------------------------------------
    // Data phase control
    // ------------------------------------------------------------------------
    // err_first/err_second are the two ERROR cycles; accept cannot coincide
    // with err_first since hready is low then
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dp_valid   <= 1'b0;
            wcnt       <= '0;
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else begin
            err_second <= err_first;
            if (accept) begin
                dp_valid  <= in_range;
                err_first <= ~in_range;
                wcnt      <= wcnt_w'(wait_states);
            end else begin
                err_first <= 1'b0;
                if (dp_valid) begin
                    if (wcnt != '0) begin
                        wcnt <= wcnt - 1'b1;
                    end else begin
                        dp_valid <= 1'b0;
                    end
                end
            end
        end
    end

    // Last cycle of an in-range data phase
    assign dp_last = dp_valid & (wcnt == '0);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    assign wdata_u = ahb_in.hwdata;

    always_ff @(posedge clk) begin
        if (dp_last & dp_write) begin
            for (int i = 0; i < lanes; i++) begin
                if (dp_be[i]) begin
                    mem[dp_idx].bytes[i] <= wdata_u.bytes[i];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Slave outputs
    // ------------------------------------------------------------------------
    always_comb begin
        ahb_out.hready = ~err_first & ~(dp_valid & (wcnt != '0));
        ahb_out.hresp  = (err_first | err_second) ? hresp_error : hresp_okay;
        // Only sampled with the final hready of a read
        ahb_out.hrdata = mem[dp_idx].word;
    end

endmodule

// ==== dmem_subsys_top.sv ====
/*
 * Data-memory subsystem top
 * Core bridge and SRAM slave joined over the AHB-Lite bus structs
 */
`timescale 1ns/1ps
`include "dmem_macros.svh"

module dmem_subsys_top
    import dmem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    // Core request port
    input  logic                       dmem_req,
    input  dmem_req_s                  dmem_cmd_in,
    output logic                       dmem_req_ack,
    output logic [`DMEM_AHB_WIDTH-1:0] dmem_rdata,
    output mem_resp_e                  dmem_resp
);

    // AHB-Lite bus, one master and one slave
    ahb_mst_s ahb_mst;
    ahb_slv_s ahb_slv;

    dmem_ahb_bridge #(
        .queue_depth (`DMEM_REQ_QUEUE_DEPTH)
    ) bridge0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .dmem_req     (dmem_req),
        .dmem_cmd_in  (dmem_cmd_in),
        .dmem_req_ack (dmem_req_ack),
        .dmem_rdata   (dmem_rdata),
        .dmem_resp    (dmem_resp),
        .ahb_out      (ahb_mst),
        .ahb_in       (ahb_slv)
    );

    ahb_sram_slave #(
        .mem_words   (`DMEM_SRAM_WORDS),
        .wait_states (`DMEM_SRAM_WAIT)
    ) sram0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .ahb_in  (ahb_mst),
        .ahb_out (ahb_slv)
    );

endmodule

// ==== tb_clock_gen.sv ====
/*
 * Testbench clock and reset source
 * Free-running clock and an active-low reset held for a few cycles
 */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2);
            clk = ~clk;
        end
    end

    // Release just after the last reset edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== tb_dmem_subsys.sv ====
/*
 * Testbench for the data-memory subsystem
 * Stimulus table, byte-wide reference memory, in-order response checks
 */
`timescale 1ns/1ps
`include "dmem_macros.svh"

module tb_dmem_subsys
    import dmem_pkg::*;
();

    localparam int aw       = `DMEM_AHB_WIDTH;
    localparam int max_wait = 50;

    typedef struct {
        mem_cmd_e      cmd;
        mem_width_e    width;
        logic [aw-1:0] addr;
        logic [aw-1:0] wdata;
        bit            exp_err;
    } row_s;

    typedef struct {
        int            row;
        bit            exp_err;
        bit            check_data;
        logic [aw-1:0] data;
    } expect_s;

    logic          clk;
    logic          rst_n;
    logic          dmem_req;
    dmem_req_s     dmem_cmd_in;
    logic          dmem_req_ack;
    logic [aw-1:0] dmem_rdata;
    mem_resp_e     dmem_resp;

    row_s          stim[$];
    expect_s       pend_q[$];
    logic [7:0]    ref_mem [1024];
    logic [31:0]   lcg_state;
    int            num_checks;
    int            num_errors;
    bit            timed_out;
    bit            saw_full;

    tb_clock_gen clock0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dmem_subsys_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .dmem_req     (dmem_req),
        .dmem_cmd_in  (dmem_cmd_in),
        .dmem_req_ack (dmem_req_ack),
        .dmem_rdata   (dmem_rdata),
        .dmem_resp    (dmem_resp)
    );

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [aw-1:0] random_word_addr();
        logic [31:0] rnd;
        rnd = next_random();
        return aw'({rnd[23:16], 2'b00});
    endfunction

    function automatic int access_bytes(input mem_width_e width);
        int n;
        case (width)
            mem_width_byte:  n = 1;
            mem_width_hword: n = 2;
            default:         n = 4;
        endcase
        return n;
    endfunction

    // Anything at or past 1 KiB is outside the SRAM
    task automatic add_row(input mem_cmd_e cmd, input mem_width_e width,
                           input logic [aw-1:0] addr, input logic [aw-1:0] wdata);
        row_s r;
        r.cmd     = cmd;
        r.width   = width;
        r.addr    = addr;
        r.wdata   = wdata;
        r.exp_err = (addr >= 32'd1024);
        stim.push_back(r);
    endtask

    task automatic drive_row(input int idx);
        dmem_req          = 1'b1;
        dmem_cmd_in.cmd   = stim[idx].cmd;
        dmem_cmd_in.width = stim[idx].width;
        dmem_cmd_in.addr  = stim[idx].addr;
        dmem_cmd_in.wdata = stim[idx].wdata;
    endtask

    // ------------------------------------------------------------------------
    // Reference model and checks
    // ------------------------------------------------------------------------
    // Accepted requests complete in order, so the model is updated on accept
    task automatic record_accept(input int idx);
        row_s    r;
        expect_s e;
        int      n;
        r            = stim[idx];
        n            = access_bytes(r.width);
        e.row        = idx;
        e.exp_err    = r.exp_err;
        e.check_data = (r.cmd == mem_cmd_rd) && !r.exp_err;
        e.data       = '0;
        if (!r.exp_err) begin
            for (int i = 0; i < n; i++) begin
                if (r.cmd == mem_cmd_wr) begin
                    ref_mem[int'(r.addr) + i] = r.wdata[8*i +: 8];
                end else begin
                    e.data[8*i +: 8] = ref_mem[int'(r.addr) + i];
                end
            end
        end
        pend_q.push_back(e);
    endtask

    task automatic check_response();
        expect_s   e;
        mem_resp_e exp_resp;
        num_checks++;
        assert (pend_q.size() != 0) else begin
            $display("a response arrived at %0t ns with no request outstanding", $time);
            num_errors++;
        end
        if (pend_q.size() != 0) begin
            e        = pend_q.pop_front();
            exp_resp = e.exp_err ? mem_resp_rdy_er : mem_resp_rdy_ok;
            num_checks++;
            assert (dmem_resp == exp_resp) else begin
                $display("error %0t: row %0d response %0d, expected %0d",
                         $time, e.row, dmem_resp, exp_resp);
                num_errors++;
            end
            if (e.check_data) begin
                num_checks++;
                assert (dmem_rdata == e.data) else begin
                    $display("error %0t: row %0d read data %h, expected %h",
                             $time, e.row, dmem_rdata, e.data);
                    num_errors++;
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Table runner, one request at a time or back to back
    // ------------------------------------------------------------------------
    task automatic run_rows(input int first, input int last, input bit streamed);
        int next_row;
        int idle;
        next_row = first;
        idle     = 0;
        while (!timed_out && ((next_row <= last) || (pend_q.size() != 0))) begin
            @(posedge clk);
            #1;
            if ((next_row <= last) && (streamed || (pend_q.size() == 0))) begin
                drive_row(next_row);
            end else begin
                dmem_req = 1'b0;
            end
            // Sample mid-cycle where outputs are settled
            @(negedge clk);
            if (dmem_resp != mem_resp_notrdy) begin
                check_response();
                idle = 0;
            end
            if (!dmem_req_ack) begin
                saw_full = 1'b1;
            end
            if (dmem_req && dmem_req_ack) begin
                record_accept(next_row);
                next_row++;
                idle = 0;
            end
            idle++;
            if (idle > max_wait) begin
                $display("timeout: no acknowledge or response for %0d cycles at %0t ns",
                         max_wait, $time);
                timed_out = 1'b1;
            end
        end
        dmem_req = 1'b0;
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while ((rst_n !== 1'b1) && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles > max_wait) begin
                $display("timeout: reset was never released");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic check_after_reset();
        repeat (4) begin
            @(negedge clk);
            num_checks++;
            assert (dmem_req_ack && (dmem_resp == mem_resp_notrdy)) else begin
                $display("error %0t: ack %0b resp %0d after reset, expected ack 1, not ready",
                         $time, dmem_req_ack, dmem_resp);
                num_errors++;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %0d errors", num, name, num_errors - errs_before);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int            first;
        int            errs;
        logic [aw-1:0] base;
        logic [aw-1:0] addrs [6];
        dmem_req    = 1'b0;
        dmem_cmd_in = '0;
        lcg_state   = 32'd64;
        num_checks  = 0;
        num_errors  = 0;
        timed_out   = 1'b0;
        saw_full    = 1'b0;

        wait_for_reset();
        errs = num_errors;
        check_after_reset();
        report_test(1, "reset state", errs);

        // Word writes, then reads of the same words
        errs  = num_errors;
        first = stim.size();
        for (int i = 0; i < 6; i++) begin
            addrs[i] = random_word_addr();
            add_row(mem_cmd_wr, mem_width_word, addrs[i], next_random());
        end
        for (int i = 0; i < 6; i++) begin
            add_row(mem_cmd_rd, mem_width_word, addrs[i], '0);
        end
        run_rows(first, stim.size() - 1, 1'b0);
        report_test(2, "word write and read", errs);

        // Sub-word writes at each lane, checked through word and lane reads
        errs  = num_errors;
        first = stim.size();
        for (int off = 0; off < 4; off++) begin
            base = random_word_addr();
            add_row(mem_cmd_wr, mem_width_word, base, next_random());
            add_row(mem_cmd_wr, mem_width_byte, base + aw'(off), next_random());
            add_row(mem_cmd_rd, mem_width_word, base, '0);
            add_row(mem_cmd_rd, mem_width_byte, base + aw'(off), '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            base = random_word_addr();
            add_row(mem_cmd_wr, mem_width_word, base, next_random());
            add_row(mem_cmd_wr, mem_width_hword, base + aw'(off), next_random());
            add_row(mem_cmd_rd, mem_width_word, base, '0);
            add_row(mem_cmd_rd, mem_width_hword, base + aw'(off), '0);
        end
        run_rows(first, stim.size() - 1, 1'b0);
        report_test(3, "byte and halfword lanes", errs);

        // Back-to-back stream, queue must fill at some point
        errs     = num_errors;
        first    = stim.size();
        saw_full = 1'b0;
        for (int i = 0; i < 4; i++) begin
            addrs[i] = random_word_addr();
            add_row(mem_cmd_wr, mem_width_word, addrs[i], next_random());
        end
        for (int i = 0; i < 4; i++) begin
            add_row(mem_cmd_wr, mem_width_byte, addrs[i] + aw'(i), next_random());
            add_row(mem_cmd_rd, mem_width_word, addrs[i], '0);
        end
        run_rows(first, stim.size() - 1, 1'b1);
        num_checks++;
        assert (saw_full) else begin
            $display("request acknowledge never went low during the back-to-back stream");
            num_errors++;
        end
        report_test(4, "back-to-back stream", errs);

        // Out-of-range accesses; the write at base + 1 KiB would alias base
        errs  = num_errors;
        first = stim.size();
        base  = random_word_addr();
        add_row(mem_cmd_wr, mem_width_word, base, next_random());
        add_row(mem_cmd_wr, mem_width_word, base + 32'd1024, next_random());
        add_row(mem_cmd_rd, mem_width_word, 32'h0000_0800, '0);
        add_row(mem_cmd_rd, mem_width_word, base, '0);
        add_row(mem_cmd_rd, mem_width_hword, base + 32'd2, '0);
        run_rows(first, stim.size() - 1, 1'b0);
        report_test(5, "error response", errs);

        $display("checks %0d, errors %0d%s", num_checks, num_errors,
                 timed_out ? ", run stopped by a timeout" : "");
        if ((num_errors == 0) && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
dmem_pkg.sv
dmem_ahb_bridge.sv
ahb_sram_slave.sv
dmem_subsys_top.sv
tb_clock_gen.sv
tb_dmem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the data-memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dmem_subsys \
    -f all.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
